// ==== logic/pe.sv ====
/*
 * Processing element
 * Weight stays put once loaded; activation moves right and the
 * partial sum moves down, both through one register stage
 */
`timescale 1ns/10ps

module pe
	import tpu_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  weight_en_i,
	input  lane_t weight_i,
	input  logic  run_i,
	input  lane_t act_i,
	input  lane_t psum_i,
	output lane_t act_o,
	output lane_t psum_o
);

	lane_t weight_q;

	always_ff @(posedge clk) begin
		if (weight_en_i)
			weight_q <= weight_i;
	end

	// Product and sum wrap at 8 bits
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			act_o  <= '0;
			psum_o <= '0;
		end else if (run_i) begin
			act_o  <= act_i;
			psum_o <= psum_i + act_i * weight_q;
		end
	end

endmodule

// ==== logic/pe_array.sv ====
/*
 * Weight-stationary PE grid
 * PE row r takes its weights from one B row during load.
 * Activations enter on the left edge, partial sums start at zero
 * on the top edge and leave on the bottom edge, one lane per column
 */
`timescale 1ns/10ps
`include "tpu_cfg.svh"

module pe_array
	import tpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       load_i,
	input  logic [2:0] load_row_i,
	input  word_t      weight_row_i,
	input  logic       run_i,
	input  word_t      left_i,
	output word_t      bottom_o
);

	// Column DIM of act_w leaves the right edge unused
	wire lane_t act_w  [0:`TPU_DIM-1][0:`TPU_DIM];
	wire lane_t psum_w [0:`TPU_DIM][0:`TPU_DIM-1];
	logic [`TPU_DIM-1:0] row_en;

	always_comb begin
		for (int r = 0; r < `TPU_DIM; r++)
			row_en[r] = load_i && (load_row_i == r);
	end

	genvar r, c;
	generate
		for (c = 0; c < `TPU_DIM; c++) begin : g_edge_col
			assign psum_w[0][c] = '0; // Top row starts the sum
			assign bottom_o[c] = psum_w[`TPU_DIM][c];
		end

		for (r = 0; r < `TPU_DIM; r++) begin : g_row
			assign act_w[r][0] = left_i[r];

			for (c = 0; c < `TPU_DIM; c++) begin : g_col
				pe u_pe (
					.clk         (clk),
					.rst         (rst),
					.weight_en_i (row_en[r]),
					.weight_i    (weight_row_i[c]),
					.run_i       (run_i),
					.act_i       (act_w[r][c]),
					.psum_i      (psum_w[r][c]),
					.act_o       (act_w[r][c+1]),
					.psum_o      (psum_w[r+1][c])
				);
			end
		end
	endgenerate

endmodule

// ==== logic/result_deskew.sv ====
/*
 * Result deskew and capture
 * Delay lines record each bottom-edge column while the array runs.
 * On capture the diagonal taps line up one C row per register,
 * and the output row register is picked by out_row_i
 */
`timescale 1ns/10ps
`include "tpu_cfg.svh"

module result_deskew
	import tpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       run_i,
	input  logic       capture_i,
	input  word_t      bottom_i,
	input  logic [2:0] out_row_i,
	output word_t      data_o_o
);

	// C[i][c] leaves the bottom i+c+DIM-1 edges into the run,
	// so at capture it sits 2*DIM-2-i-c lanes down its line
	localparam int TAP_BASE = 2 * `TPU_DIM - 2;

	lane_t down_q [0:`TPU_DIM-1][0:`TPU_DOWN_DEPTH-1];
	word_t row_q  [0:`TPU_DIM-1];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int c = 0; c < `TPU_DIM; c++)
				for (int q = 0; q < `TPU_DOWN_DEPTH; q++)
					down_q[c][q] <= '0;
		end else if (run_i) begin
			for (int c = 0; c < `TPU_DIM; c++) begin
				down_q[c][0] <= bottom_i[c];
				for (int q = 0; q < `TPU_DOWN_DEPTH - 1; q++)
					down_q[c][q+1] <= down_q[c][q];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture_i) begin
			for (int i = 0; i < `TPU_DIM; i++)
				for (int c = 0; c < `TPU_DIM; c++)
					row_q[i][c] <= down_q[c][TAP_BASE-i-c];
		end
	end

	assign data_o_o = row_q[out_row_i]; // Row being written out

endmodule

// ==== logic/skew_feeder.sv ====
/*
 * Skewed activation feeder
 * One shift line per array row. Line r holds A column r behind r
 * zero lanes, so row r of the array starts r cycles later.
 * Position 0 of each line drives the left edge
 */
`timescale 1ns/10ps
`include "tpu_cfg.svh"

module skew_feeder
	import tpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       clear_i,
	input  logic       load_i,
	input  logic [2:0] load_row_i,
	input  word_t      data_a_i,
	input  logic       run_i,
	output word_t      left_o
);

	lane_t line_q [0:`TPU_DIM-1][0:`TPU_LEFT_DEPTH-1];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int r = 0; r < `TPU_DIM; r++)
				for (int p = 0; p < `TPU_LEFT_DEPTH; p++)
					line_q[r][p] <= '0;
		end else if (clear_i) begin
			// Rows not loaded this run must feed zeros
			for (int r = 0; r < `TPU_DIM; r++)
				for (int p = 0; p < `TPU_LEFT_DEPTH; p++)
					line_q[r][p] <= '0;
		end else if (load_i) begin
			for (int r = 0; r < `TPU_DIM; r++) begin
				if (load_row_i == r) begin
					for (int p = 0; p < `TPU_LEFT_DEPTH; p++) begin
						if (p >= r && p < r + `TPU_DIM)
							line_q[r][p] <= data_a_i[p-r];
						else
							line_q[r][p] <= '0; // Skew padding
					end
				end
			end
		end else if (run_i) begin
			for (int r = 0; r < `TPU_DIM; r++) begin
				for (int p = 0; p < `TPU_LEFT_DEPTH - 1; p++)
					line_q[r][p] <= line_q[r][p+1];
				line_q[r][`TPU_LEFT_DEPTH-1] <= '0;
			end
		end
	end

	always_comb begin
		for (int r = 0; r < `TPU_DIM; r++)
			left_o[r] = line_q[r][0];
	end

endmodule

// ==== logic/tpu_cfg.svh ====
/*
 * Systolic matrix multiplier configuration
 * Array size, lane and word widths, buffer index width and the
 * lengths of the skew and deskew delay lines
 */
`ifndef TPU_CFG_SVH
`define TPU_CFG_SVH

`define TPU_DIM 5 // PEs per side
`define TPU_LANE_W 8
`define TPU_WORD_W 40 // DIM lanes per buffer word
`define TPU_IDX_W 8

// Skewed feeder line of 2*DIM lanes
`define TPU_LEFT_DEPTH 10
`define TPU_DOWN_DEPTH 14 // Bottom edge delay line

`define TPU_EXE_CYCLES 14

`endif

// ==== logic/tpu_ctrl.sv ====
/*
 * Matrix multiplier controller
 * IDLE, LOAD k words, EXE a fixed number of cycles, STORE one
 * cycle, OUTPUT m words, then DONE until the next start.
 * One counter serves the load, execute and output phases
 */
`timescale 1ns/10ps
`include "tpu_cfg.svh"

module tpu_ctrl
	import tpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,
	input  logic [3:0]            m_i,
	input  logic [3:0]            k_i,
	output logic                  clear_o,
	output logic                  load_o,
	output logic [2:0]            load_row_o,
	output logic                  run_o,
	output logic                  capture_o,
	output logic [2:0]            out_row_o,
	output logic [`TPU_IDX_W-1:0] index_a_o,
	output logic [`TPU_IDX_W-1:0] index_b_o,
	output logic [`TPU_IDX_W-1:0] index_o_o,
	output logic                  wr_en_o_o,
	output logic                  done_o
);

	localparam logic [3:0] EXE_LAST = `TPU_EXE_CYCLES - 1;

	tpu_state_e state, state_nxt;
	logic [3:0] cnt; // Phase counter
	logic [3:0] k_q, m_q;
	logic [`TPU_IDX_W-1:0] cnt_idx;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE, DONE: begin
				if (start_i)
					state_nxt = LOAD;
			end
			LOAD: begin
				if (cnt == k_q - 4'd1)
					state_nxt = EXE;
			end
			EXE: begin
				if (cnt == EXE_LAST)
					state_nxt = STORE;
			end
			STORE: state_nxt = OUTPUT;
			OUTPUT: begin
				if (cnt == m_q - 4'd1)
					state_nxt = DONE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			cnt   <= '0;
			k_q   <= '0;
			m_q   <= '0;
		end else begin
			state <= state_nxt;
			if (state != state_nxt)
				cnt <= '0; // Every phase counts from zero
			else if (state == LOAD || state == EXE || state == OUTPUT)
				cnt <= cnt + 4'd1;
			if (clear_o) begin
				k_q <= k_i; // Tile size held for the whole run
				m_q <= m_i;
			end
		end
	end

	// Start pulse also clears the feeder lines
	assign clear_o = start_i && (state == IDLE || state == DONE);

	assign load_o    = (state == LOAD);
	assign run_o     = (state == EXE);
	assign capture_o = (state == STORE);
	assign wr_en_o_o = (state == OUTPUT);
	assign done_o    = (state == DONE);

	assign cnt_idx    = {{(`TPU_IDX_W-4){1'b0}}, cnt};
	assign load_row_o = cnt[2:0];
	assign out_row_o  = cnt[2:0];
	assign index_a_o  = cnt_idx; // A and B words read in step
	assign index_b_o  = cnt_idx;
	assign index_o_o  = cnt_idx;

endmodule

// ==== logic/tpu_pkg.sv ====
/*
 * Systolic matrix multiplier types
 * Operand lane, buffer word and controller state encoding
 */
`include "tpu_cfg.svh"

package tpu_pkg;

	// One operand or 8-bit partial sum
	typedef logic [`TPU_LANE_W-1:0] lane_t;

	// Lane 0 sits in the top byte
	typedef lane_t [0:`TPU_DIM-1] word_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		EXE,
		STORE,
		OUTPUT,
		DONE
	} tpu_state_e;

endpackage

// ==== logic/tpu_top.sv ====
/*
 * Weight-stationary 5x5 systolic matrix multiplier
 * Reads A columns and B rows from outside buffers, runs the PE
 * grid and writes the C rows back one word per cycle
 */
`timescale 1ns/10ps
`include "tpu_cfg.svh"

module tpu_top
	import tpu_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start_i,
	input  logic [3:0]             m_i,
	input  logic [3:0]             k_i,
	input  logic [`TPU_WORD_W-1:0] data_a_i,
	input  logic [`TPU_WORD_W-1:0] data_b_i,
	output logic [`TPU_IDX_W-1:0]  index_a_o,
	output logic [`TPU_IDX_W-1:0]  index_b_o,
	output logic [`TPU_IDX_W-1:0]  index_o_o,
	output logic [`TPU_WORD_W-1:0] data_o_o,
	output logic                   wr_en_o_o,
	output logic                   done_o
);

	logic       clear;
	logic       load;
	logic [2:0] load_row;
	logic       run;
	logic       capture;
	logic [2:0] out_row;
	word_t      left_w;   // Feeder to array
	word_t      bottom_w; // Array to deskew

	tpu_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.start_i    (start_i),
		.m_i        (m_i),
		.k_i        (k_i),
		.clear_o    (clear),
		.load_o     (load),
		.load_row_o (load_row),
		.run_o      (run),
		.capture_o  (capture),
		.out_row_o  (out_row),
		.index_a_o  (index_a_o),
		.index_b_o  (index_b_o),
		.index_o_o  (index_o_o),
		.wr_en_o_o  (wr_en_o_o),
		.done_o     (done_o)
	);

	skew_feeder u_feeder (
		.clk        (clk),
		.rst        (rst),
		.clear_i    (clear),
		.load_i     (load),
		.load_row_i (load_row),
		.data_a_i   (data_a_i),
		.run_i      (run),
		.left_o     (left_w)
	);

	pe_array u_array (
		.clk          (clk),
		.rst          (rst),
		.load_i       (load),
		.load_row_i   (load_row),
		.weight_row_i (data_b_i),
		.run_i        (run),
		.left_i       (left_w),
		.bottom_o     (bottom_w)
	);

	result_deskew u_deskew (
		.clk       (clk),
		.rst       (rst),
		.run_i     (run),
		.capture_i (capture),
		.bottom_i  (bottom_w),
		.out_row_i (out_row),
		.data_o_o  (data_o_o)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the matrix multiplier testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_tpu --Mdir obj_dir -o tb_tpu_sim; then
	echo "Verilator compile failed"
	exit 1
fi

if ! ./obj_dir/tb_tpu_sim > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== src.f ====
+incdir+logic
logic/tpu_pkg.sv
logic/pe.sv
logic/pe_array.sv
logic/skew_feeder.sv
logic/result_deskew.sv
logic/tpu_ctrl.sv
logic/tpu_top.sv
verification/tpu_assert.sv
verification/tb_tpu.sv

// ==== verification/tb_tpu.sv ====
/*
 * Testbench for the systolic matrix multiplier
 * Models the A, B and C buffers, runs full, small, identity,
 * overflow, back-to-back and reset-interrupted tiles and checks
 * every written C word against a reference product
 */
`timescale 1ns/10ps
`include "tpu_cfg.svh"

module tb_tpu;

	localparam int NUM_RUNS = 8;
	localparam int SLACK    = 12;
	localparam int RUN_MAX  = 1 + 5 + 14 + 1 + 5 + SLACK;
	localparam int LIMIT    = NUM_RUNS * RUN_MAX + 3 * 8; // Runs plus resets

	logic                   clk;
	logic                   rst;
	logic                   start_i;
	logic [3:0]             m_i;
	logic [3:0]             k_i;
	logic [`TPU_WORD_W-1:0] data_a_i;
	logic [`TPU_WORD_W-1:0] data_b_i;
	logic [`TPU_IDX_W-1:0]  index_a_o;
	logic [`TPU_IDX_W-1:0]  index_b_o;
	logic [`TPU_IDX_W-1:0]  index_o_o;
	logic [`TPU_WORD_W-1:0] data_o_o;
	logic                   wr_en_o_o;
	logic                   done_o;

	logic [`TPU_WORD_W-1:0] a_mem [0:255];
	logic [`TPU_WORD_W-1:0] b_mem [0:255];
	logic [`TPU_WORD_W-1:0] c_mem [0:255];
	logic [`TPU_WORD_W-1:0] exp_c [0:`TPU_DIM-1];
	logic [7:0] a_mat [0:`TPU_DIM-1][0:`TPU_DIM-1];
	logic [7:0] b_mat [0:`TPU_DIM-1][0:`TPU_DIM-1];

	integer seed;
	int cycle_cnt;
	int data_errs;
	int other_errs;
	int writes;   // Words written since time zero
	int run_base; // Value of writes at the current start
	int cur_m;

	tpu_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.start_i   (start_i),
		.m_i       (m_i),
		.k_i       (k_i),
		.data_a_i  (data_a_i),
		.data_b_i  (data_b_i),
		.index_a_o (index_a_o),
		.index_b_o (index_b_o),
		.index_o_o (index_o_o),
		.data_o_o  (data_o_o),
		.wr_en_o_o (wr_en_o_o),
		.done_o    (done_o)
	);

	bind tpu_ctrl tpu_assert u_assert (
		.clk     (clk),
		.rst     (rst),
		.start_i (start_i),
		.k_i     (k_q),
		.load_i  (load_o),
		.wr_en_i (wr_en_o_o),
		.done_i  (done_o)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Asynchronous buffer reads
	assign data_a_i = a_mem[index_a_o];
	assign data_b_i = b_mem[index_b_o];

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > LIMIT) begin
			$display("Timeout after %0d cycles without finishing the tests", LIMIT);
			$display("Errors: %0d data, %0d other", data_errs, other_errs);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Buffer write and compare
	always @(posedge clk) begin
		if (!rst && wr_en_o_o) begin
			c_mem[index_o_o] <= data_o_o;
			assert (writes - run_base < cur_m && index_o_o == writes - run_base) else begin
				$display("Write to word %0d is out of order or beyond the tile", index_o_o);
				other_errs++;
			end
			if (writes - run_base < `TPU_DIM) begin
				assert (data_o_o === exp_c[writes - run_base]) else begin
					$display("FAIL %0t data_o_o[%0d] expected %h actual %h", $time,
						index_o_o, exp_c[writes - run_base], data_o_o);
					data_errs++;
				end
			end
			writes++;
		end
	end

	// C row as one word with sums wrapping at 256
	function automatic logic [`TPU_WORD_W-1:0] ref_matmul(input int row, input int k);
		logic [`TPU_WORD_W-1:0] w;
		int sum;
		w = '0;
		for (int c = 0; c < `TPU_DIM; c++) begin
			sum = 0;
			for (int t = 0; t < k; t++)
				sum = (sum + a_mat[row][t] * b_mat[t][c]) % 256;
			w[`TPU_WORD_W-1-8*c -: 8] = sum[7:0];
		end
		return w;
	endfunction

	// Mode 0 random, 1 identity B, 2 all 255
	task automatic fill_tile(input int m, input int k, input int mode);
		logic [31:0] rnd;
		for (int i = 0; i < `TPU_DIM; i++) begin
			for (int t = 0; t < `TPU_DIM; t++) begin
				rnd = $random(seed);
				a_mat[i][t] = (i < m && t < k) ? ((mode == 2) ? 8'hff : rnd[7:0]) : 8'h00;
				rnd = $random(seed);
				if (t >= k)
					b_mat[t][i] = 8'h00; // Padding row
				else if (mode == 1)
					b_mat[t][i] = (t == i) ? 8'h01 : 8'h00;
				else
					b_mat[t][i] = (mode == 2) ? 8'hff : rnd[7:0];
			end
		end
		for (int t = 0; t < `TPU_DIM; t++) begin
			for (int l = 0; l < `TPU_DIM; l++) begin
				a_mem[t][`TPU_WORD_W-1-8*l -: 8] = a_mat[l][t];
				b_mem[t][`TPU_WORD_W-1-8*l -: 8] = b_mat[t][l];
			end
		end
		for (int i = 0; i < `TPU_DIM; i++) begin
			exp_c[i] = ref_matmul(i, k);
			c_mem[i] = '0;
		end
	endtask

	task automatic start_tile(input int m, input int k);
		cur_m = m;
		run_base = writes;
		m_i = m[3:0];
		k_i = k[3:0];
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
	endtask

	task automatic run_tile(input int m, input int k);
		int cycles;
		start_tile(m, k);
		cycles = 1;
		while (!done_o) begin
			if (cycles <= k) begin // LOAD reads word cycles-1
				assert (index_a_o == cycles - 1) else begin
					$display("FAIL %0t index_a_o expected %0d actual %0d", $time,
						cycles - 1, index_a_o);
					other_errs++;
				end
				assert (index_b_o == cycles - 1) else begin
					$display("FAIL %0t index_b_o expected %0d actual %0d", $time,
						cycles - 1, index_b_o);
					other_errs++;
				end
			end
			@(negedge clk);
			cycles++;
		end
		assert (cycles == k + m + 16) else begin
			$display("done_o came %0d cycles after start instead of %0d", cycles, k + m + 16);
			other_errs++;
		end
		assert (writes - run_base == m) else begin
			$display("Tile wrote %0d words instead of %0d", writes - run_base, m);
			other_errs++;
		end
		for (int i = m; i < `TPU_DIM; i++) begin
			assert (c_mem[i] === '0) else begin
				$display("Word %0d was written although it lies outside the tile", i);
				other_errs++;
			end
		end
	endtask

	initial begin
		seed = 26;
		rst = 1'b1;
		start_i = 1'b0;
		m_i = '0;
		k_i = '0;
		cycle_cnt = 0;
		data_errs = 0;
		other_errs = 0;
		writes = 0;
		run_base = 0;
		cur_m = 0;
		for (int w = 0; w < 256; w++) begin
			a_mem[w] = '0;
			b_mem[w] = '0;
			c_mem[w] = '0;
		end
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		fill_tile(5, 5, 0);
		run_tile(5, 5);
		fill_tile(5, 5, 1); // Lane order
		run_tile(5, 5);
		fill_tile(2, 3, 0);
		run_tile(2, 3);
		fill_tile(5, 5, 2); // Wraparound
		run_tile(5, 5);

		// Back to back where the smaller k must see no stale rows
		fill_tile(4, 5, 0);
		run_tile(4, 5);
		fill_tile(5, 2, 0);
		run_tile(5, 2);

		// Reset while C words are going out
		fill_tile(5, 5, 0);
		start_tile(5, 5);
		while (!wr_en_o_o)
			@(negedge clk);
		@(negedge clk);
		rst = 1'b1;
		#1;
		assert (!wr_en_o_o && !done_o) else begin
			$display("Reset did not clear wr_en_o_o and done_o at once");
			other_errs++;
		end
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		fill_tile(3, 4, 0);
		run_tile(3, 4);

		$display("Errors: %0d data, %0d other", data_errs, other_errs);
		if (data_errs == 0 && other_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== verification/tpu_assert.sv ====
/*
 * Controller protocol checks
 * Bound into tpu_ctrl; watches write enable, done and LOAD length
 */
`timescale 1ns/10ps

module tpu_assert (
	input logic       clk,
	input logic       rst,
	input logic       start_i,
	input logic [3:0] k_i, // Latched tile depth
	input logic       load_i,
	input logic       wr_en_i,
	input logic       done_i
);

	logic [3:0] load_len;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			load_len <= '0;
		else if (load_i)
			load_len <= load_len + 4'd1;
		else
			load_len <= '0;
	end

	// A write is followed by one more write or by done alone
	a_write_then_done: assert property (@(posedge clk) disable iff (rst)
		wr_en_i |=> (wr_en_i != done_i))
		else $error("wr_en_o_o was not followed by another write or by done_o alone");

	// Done only drops on a new start
	a_done_holds: assert property (@(posedge clk) disable iff (rst)
		(done_i && !start_i) |=> done_i)
		else $error("done_o dropped without start_i");

	a_load_length: assert property (@(posedge clk) disable iff (rst)
		$fell(load_i) |-> (load_len == k_i))
		else $error("LOAD did not last k cycles");

endmodule
